//--- common/hl_defs.svh
// Width, address and timing constants for the host command path.
// Included by the shared package, the RTL blocks and the testbench.

`ifndef HL_DEFS_SVH
`define HL_DEFS_SVH

// command word widths
`define HL_CMD_ADDR_W     6
`define HL_CMD_DATA_W     32

// AD9866 serial port
`define HL_SPI_W          16
// clk_ctrl cycles per half sclk period
`define HL_SPI_HALF       2

// command addresses
`define HL_ADDR_KEY       6'h00
`define HL_ADDR_IP        6'h39
`define HL_ADDR_MAC       6'h3A
`define HL_ADDR_AD9866    6'h3B

// keying bits in the data word
`define HL_KEY_RUN_BIT    0
`define HL_KEY_PTT_BIT    1
`define HL_KEY_CW_BIT     2

// config byte bit that selects the alternate MAC
`define HL_CFG_ALTMAC_BIT 6

`define HL_MAC_BASE       48'h001CC0A213DD

`endif

//--- common/hl_pkg.sv
// Shared types for the host command path.
// Imported by the interface, the RTL blocks and the testbench.

`include "hl_defs.svh"

package hl_pkg;

  typedef logic [`HL_CMD_ADDR_W-1:0] cmd_addr_t;
  typedef logic [`HL_CMD_DATA_W-1:0] cmd_data_t;

  // one AD9866 register write, address and value together
  typedef logic [`HL_SPI_W-1:0] spi_word_t;

  typedef logic [47:0] mac_t;

  // decoded command targets
  typedef enum logic [2:0] {
    OP_NONE,
    OP_KEY,
    OP_IP,
    OP_MAC,
    OP_SPI
  } cmd_op_e;

  // host handshake FSM
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_EXEC,
    ST_WAIT_SPI,
    ST_ACK
  } ctrl_state_e;

  // 40-bit response word returned to the host
  typedef struct packed {
    logic      run;
    logic      tx_on;
    cmd_addr_t addr;
    cmd_data_t data;
  } resp_t;

endpackage

//--- common/cmd_if.sv
// Dispatch bus between the command controller and the datapath blocks.
// One-cycle write strobes share a single data word; status flows back.

`timescale 1ns/1ns

interface cmd_if
  import hl_pkg::*;
();

  cmd_data_t wr_data;
  logic      wr_key;
  logic      wr_ip;
  logic      wr_mac;
  logic      wr_spi;

  // status back to the controller
  logic      spi_busy;
  logic      run;
  logic      tx_on;

  modport ctrl (
    output wr_data, wr_key, wr_ip, wr_mac, wr_spi,
    input  spi_busy, run, tx_on
  );

  modport key   (input wr_data, wr_key, output run, tx_on);
  modport ident (input wr_data, wr_ip, wr_mac);
  modport spi   (input wr_data, wr_spi, output spi_busy);

endinterface

//--- hw/cmd_ctrl.sv
// Host command controller.
// Accepts a command over a four-phase req/ack handshake, decodes its
// address, pulses one dispatch strobe and latches the response word.

`timescale 1ns/1ns

`include "hl_defs.svh"

module cmd_ctrl
  import hl_pkg::*;
(
  input  logic      clk_ctrl,
  input  logic      rst_n_i,
  input  logic      cmd_req_i,
  input  cmd_addr_t cmd_addr_i,
  input  cmd_data_t cmd_data_i,
  input  logic      cmd_resp_req_i,
  output logic      cmd_ack_o,
  output resp_t     resp_o,
  cmd_if.ctrl       bus
);

  ctrl_state_e state_q;
  cmd_addr_t   addr_q;
  cmd_data_t   data_q;
  logic        resp_req_q;
  logic        load_resp_q;
  cmd_op_e     op;

  ////////////////////////////////////////////////////////////
  // command capture and decode

  // held for the whole command, host may change inputs after ack
  always_ff @(posedge clk_ctrl) begin
    if (state_q == ST_IDLE && cmd_req_i) begin
      addr_q     <= cmd_addr_i;
      data_q     <= cmd_data_i;
      resp_req_q <= cmd_resp_req_i;
    end
  end

  always_comb begin
    case (addr_q)
      `HL_ADDR_KEY:    op = OP_KEY;
      `HL_ADDR_IP:     op = OP_IP;
      `HL_ADDR_MAC:    op = OP_MAC;
      `HL_ADDR_AD9866: op = OP_SPI;
      // unused addresses are acked and dropped
      default:         op = OP_NONE;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // handshake FSM

  always_ff @(posedge clk_ctrl) begin
    if (!rst_n_i) begin
      state_q     <= ST_IDLE;
      load_resp_q <= 1'b0;
    end else begin
      load_resp_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (cmd_req_i) begin
            state_q <= ST_EXEC;
          end
        end
        ST_EXEC: begin
          if (op == OP_SPI) begin
            state_q <= ST_WAIT_SPI;
          end else begin
            state_q     <= ST_ACK;
            load_resp_q <= resp_req_q;
          end
        end
        ST_WAIT_SPI: begin
          // busy is already high here, set on the strobe edge
          if (!bus.spi_busy) begin
            state_q     <= ST_ACK;
            load_resp_q <= resp_req_q;
          end
        end
        ST_ACK: begin
          if (!cmd_req_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  assign cmd_ack_o = (state_q == ST_ACK);

  // one strobe per command, only in ST_EXEC
  assign bus.wr_data = data_q;
  assign bus.wr_key  = (state_q == ST_EXEC) && (op == OP_KEY);
  assign bus.wr_ip   = (state_q == ST_EXEC) && (op == OP_IP);
  assign bus.wr_mac  = (state_q == ST_EXEC) && (op == OP_MAC);
  assign bus.wr_spi  = (state_q == ST_EXEC) && (op == OP_SPI);

  ////////////////////////////////////////////////////////////
  // response latch

  // armed on entry to ST_ACK, keying registers written on the strobe
  // edge are visible by the time it loads
  always_ff @(posedge clk_ctrl) begin
    if (!rst_n_i) begin
      resp_o <= '0;
    end else if (load_resp_q) begin
      resp_o.run   <= bus.run;
      resp_o.tx_on <= bus.tx_on;
      resp_o.addr  <= addr_q;
      resp_o.data  <= data_q;
    end
  end

endmodule

//--- hw/radio_keying.sv
// Transmit keying registers.
// Holds run, PTT and CW key from the keying command and gates the
// transmitter with the synchronized transmit-inhibit pin.

`timescale 1ns/1ns

`include "hl_defs.svh"

module radio_keying (
  input  logic clk_ctrl,
  input  logic rst_n_i,
  input  logic tx_inhibit_i,
  cmd_if.key   bus,
  output logic tx_on_o,
  output logic led_run_o,
  output logic led_tx_o
);

  logic run_q;
  logic ptt_q;
  logic cw_q;
  logic inhibit_meta_q;
  logic inhibit_sync_q;
  logic tx_on;

  always_ff @(posedge clk_ctrl) begin
    if (!rst_n_i) begin
      run_q <= 1'b0;
      ptt_q <= 1'b0;
      cw_q  <= 1'b0;
    end else if (bus.wr_key) begin
      run_q <= bus.wr_data[`HL_KEY_RUN_BIT];
      ptt_q <= bus.wr_data[`HL_KEY_PTT_BIT];
      cw_q  <= bus.wr_data[`HL_KEY_CW_BIT];
    end
  end

  // two-flop synchronizer for the external inhibit pin
  // comes out of reset inhibited
  always_ff @(posedge clk_ctrl) begin
    if (!rst_n_i) begin
      inhibit_meta_q <= 1'b1;
      inhibit_sync_q <= 1'b1;
    end else begin
      inhibit_meta_q <= tx_inhibit_i;
      inhibit_sync_q <= inhibit_meta_q;
    end
  end

  assign tx_on = (ptt_q | cw_q) & ~inhibit_sync_q;

  assign tx_on_o   = tx_on;
  assign led_run_o = run_q;
  assign led_tx_o  = tx_on;

  // status for the response word
  assign bus.run   = run_q;
  assign bus.tx_on = tx_on;

endmodule

//--- hw/identity_regs.sv
// Station identity registers.
// Stores the static IP, alternate MAC and config byte from host
// commands and composes the local MAC from them and the board pin.

`timescale 1ns/1ns

`include "hl_defs.svh"

module identity_regs
  import hl_pkg::*;
(
  input  logic      clk_ctrl,
  input  logic      rst_n_i,
  input  logic      alternate_mac_i,
  cmd_if.ident      bus,
  output mac_t      local_mac_o,
  output cmd_data_t static_ip_o
);

  localparam mac_t mac_base = `HL_MAC_BASE;

  cmd_data_t   static_ip_q;
  logic [15:0] alt_mac_q;
  logic [7:0]  config_q;

  always_ff @(posedge clk_ctrl) begin
    if (!rst_n_i) begin
      static_ip_q <= '0;
      alt_mac_q   <= '0;
      config_q    <= '0;
    end else begin
      if (bus.wr_ip) begin
        static_ip_q <= bus.wr_data;
      end
      if (bus.wr_mac) begin
        alt_mac_q <= bus.wr_data[15:0];
        config_q  <= bus.wr_data[23:16];
      end
    end
  end

  // alternate MAC replaces the low 16 bits, else the pin flips bit 1
  assign local_mac_o = config_q[`HL_CFG_ALTMAC_BIT] ?
                       {mac_base[47:16], alt_mac_q} :
                       {mac_base[47:2], ~alternate_mac_i, mac_base[0]};

  assign static_ip_o = static_ip_q;

endmodule

//--- hw/ad9866/ad9866_spi.sv
// Serial register writer for the AD9866 front-end converter.
// Loads a 16-bit word on wr_spi and shifts it out MSB first, framed
// by sen_n low, with sclk derived from clk_ctrl by a half-period divider.

`timescale 1ns/1ns

`include "hl_defs.svh"

module ad9866_spi
  import hl_pkg::*;
(
  input  logic clk_ctrl,
  input  logic rst_n_i,
  cmd_if.spi   bus,
  output logic sclk_o,
  output logic sdio_o,
  output logic sen_n_o
);

  localparam int div_w = $clog2(`HL_SPI_HALF + 1);
  localparam int cnt_w = $clog2(`HL_SPI_W);

  logic             active_q;
  logic             sclk_q;
  logic [div_w-1:0] div_q;
  logic [cnt_w-1:0] bit_q;
  spi_word_t        shift_q;
  logic             half_done;

  // end of one sclk half period
  assign half_done = (div_q == div_w'(`HL_SPI_HALF - 1));

  ////////////////////////////////////////////////////////////
  // frame sequencer

  always_ff @(posedge clk_ctrl) begin
    if (!rst_n_i) begin
      active_q <= 1'b0;
      sclk_q   <= 1'b0;
      div_q    <= '0;
      bit_q    <= '0;
      shift_q  <= '0;
    end else if (!active_q) begin
      sclk_q <= 1'b0;
      div_q  <= '0;
      bit_q  <= '0;
      if (bus.wr_spi) begin
        active_q <= 1'b1;
        shift_q  <= bus.wr_data[`HL_SPI_W-1:0];
      end
    end else if (half_done) begin
      div_q  <= '0;
      sclk_q <= ~sclk_q;
      if (sclk_q) begin
        // falling sclk, next bit goes out during the low phase
        shift_q <= {shift_q[`HL_SPI_W-2:0], 1'b0};
        bit_q   <= bit_q + 1'b1;
        if (bit_q == cnt_w'(`HL_SPI_W - 1)) begin
          // last bit clocked, release the frame
          active_q <= 1'b0;
        end
      end
    end else begin
      div_q <= div_q + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // pins and status

  assign sclk_o  = sclk_q;
  // shift register drains to zero, so sdio idles low
  assign sdio_o  = shift_q[`HL_SPI_W-1];
  assign sen_n_o = ~active_q;

  assign bus.spi_busy = active_q;

endmodule

//--- hw/hl_core.sv
// Top level of the host command path on clk_ctrl.
// Ties the command controller to the keying, identity and AD9866
// serial blocks over the dispatch bus and exposes their pins.

`timescale 1ns/1ns

module hl_core
  import hl_pkg::*;
(
  input  logic      clk_ctrl,
  input  logic      rst_n_i,

  // host command handshake
  input  logic      cmd_req_i,
  input  cmd_addr_t cmd_addr_i,
  input  cmd_data_t cmd_data_i,
  input  logic      cmd_resp_req_i,
  output logic      cmd_ack_o,
  output resp_t     resp_o,

  // AD9866 serial port
  output logic      rffe_ad9866_sclk_o,
  output logic      rffe_ad9866_sdio_o,
  output logic      rffe_ad9866_sen_n_o,

  // keying and board IO
  input  logic      tx_inhibit_i,
  input  logic      alternate_mac_i,
  output logic      tx_on_o,
  output logic      led_run_o,
  output logic      led_tx_o,

  // station identity
  output mac_t      local_mac_o,
  output cmd_data_t static_ip_o
);

  cmd_if u_bus ();

  cmd_ctrl u_ctrl (
    .clk_ctrl       (clk_ctrl),
    .rst_n_i        (rst_n_i),
    .cmd_req_i      (cmd_req_i),
    .cmd_addr_i     (cmd_addr_i),
    .cmd_data_i     (cmd_data_i),
    .cmd_resp_req_i (cmd_resp_req_i),
    .cmd_ack_o      (cmd_ack_o),
    .resp_o         (resp_o),
    .bus            (u_bus.ctrl)
  );

  radio_keying u_keying (
    .clk_ctrl     (clk_ctrl),
    .rst_n_i      (rst_n_i),
    .tx_inhibit_i (tx_inhibit_i),
    .bus          (u_bus.key),
    .tx_on_o      (tx_on_o),
    .led_run_o    (led_run_o),
    .led_tx_o     (led_tx_o)
  );

  identity_regs u_ident (
    .clk_ctrl        (clk_ctrl),
    .rst_n_i         (rst_n_i),
    .alternate_mac_i (alternate_mac_i),
    .bus             (u_bus.ident),
    .local_mac_o     (local_mac_o),
    .static_ip_o     (static_ip_o)
  );

  ad9866_spi u_spi (
    .clk_ctrl (clk_ctrl),
    .rst_n_i  (rst_n_i),
    .bus      (u_bus.spi),
    .sclk_o   (rffe_ad9866_sclk_o),
    .sdio_o   (rffe_ad9866_sdio_o),
    .sen_n_o  (rffe_ad9866_sen_n_o)
  );

endmodule

//--- sim/hl_core_assert.sv
// Concurrent protocol checks for the host command path.
// Bound to every hl_core instance, watches the handshake, the
// AD9866 frame and the transmit-inhibit gating.

`timescale 1ns/1ns

module hl_core_assert (
  input logic clk_ctrl,
  input logic rst_n_i,
  input logic cmd_req_i,
  input logic cmd_ack_o,
  input logic rffe_ad9866_sclk_o,
  input logic rffe_ad9866_sen_n_o,
  input logic tx_inhibit_i,
  input logic tx_on_o
);

  // ack only rises while a request is pending
  ack_needs_req: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    $rose(cmd_ack_o) |-> cmd_req_i)
    else $error("cmd_ack_o rose while cmd_req_i was low");

  // ack drops one edge after the request goes away
  ack_release: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    (cmd_ack_o && !cmd_req_i) |=> !cmd_ack_o)
    else $error("cmd_ack_o did not fall after cmd_req_i went low");

  // no serial clock outside a frame
  sclk_framed: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    rffe_ad9866_sen_n_o |-> !rffe_ad9866_sclk_o)
    else $error("sclk high while sen_n is high");

  // inhibit through the two-flop synchronizer
  inhibit_gates_tx: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    ($past(tx_inhibit_i, 2) && $past(tx_inhibit_i) && tx_inhibit_i) |-> !tx_on_o)
    else $error("tx_on high with transmit inhibit held");

endmodule

bind hl_core hl_core_assert u_assert (.*);

//--- sim/hl_core_tb.sv
// Testbench for the host command path.
// Applies a table of host commands through the four-phase handshake
// and checks keying, identity, AD9866 frames and the response word.

`timescale 1ns/1ns

`include "hl_defs.svh"

module hl_core_tb import hl_pkg::*; ();

  localparam int n_tests        = 15;
  localparam int timeout_cycles = 16 + 120 * n_tests;

  typedef struct packed {
    cmd_addr_t addr;
    cmd_data_t data;
    logic      resp_req;
    logic      inhibit;
    logic      alt_pin;
  } entry_t;

  logic      clk_ctrl;
  logic      rst_n_i;
  logic      cmd_req_i;
  cmd_addr_t cmd_addr_i;
  cmd_data_t cmd_data_i;
  logic      cmd_resp_req_i;
  logic      tx_inhibit_i;
  logic      alternate_mac_i;
  logic      cmd_ack_o;
  resp_t     resp_o;
  logic      rffe_ad9866_sclk_o;
  logic      rffe_ad9866_sdio_o;
  logic      rffe_ad9866_sen_n_o;
  logic      tx_on_o;
  logic      led_run_o;
  logic      led_tx_o;
  mac_t      local_mac_o;
  cmd_data_t static_ip_o;

  entry_t    tests [n_tests];
  string     names [n_tests];
  entry_t    cur;
  cmd_data_t cur_data;
  logic [31:0] rng;
  int        cycle_cnt;

  // reference model state
  logic        m_run;
  logic        m_ptt;
  logic        m_cw;
  logic        m_tx_on;
  cmd_data_t   m_ip;
  logic [15:0] m_alt_mac;
  logic [7:0]  m_cfg;
  resp_t       m_resp;

  // captured AD9866 frame
  spi_word_t spi_cap;
  cmd_data_t spi_rises;

  hl_core u_dut (.*);

  always #10 clk_ctrl = ~clk_ctrl;

  // cleared at frame start and shifted on each rising sclk
  always @(posedge rffe_ad9866_sclk_o or negedge rffe_ad9866_sen_n_o) begin
    if (rffe_ad9866_sclk_o) begin
      if (!rffe_ad9866_sen_n_o) begin
        spi_cap   <= {spi_cap[`HL_SPI_W-2:0], rffe_ad9866_sdio_o};
        spi_rises <= spi_rises + 1;
      end
    end else begin
      spi_cap   <= '0;
      spi_rises <= '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // helpers

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // factory MAC or the alternate MAC in the low half
  function automatic mac_t expect_mac(input logic [15:0] alt, input logic [7:0] cfg,
                                      input logic pin);
    mac_t base;
    base = `HL_MAC_BASE;
    if (cfg[`HL_CFG_ALTMAC_BIT]) begin
      return {base[47:16], alt};
    end
    base[1] = ~pin;
    return base;
  endfunction

  task automatic set_entry(input int idx, input string name, input cmd_addr_t addr,
                           input cmd_data_t data, input logic resp_req,
                           input logic inhibit, input logic alt_pin);
    names[idx]          = name;
    tests[idx].addr     = addr;
    tests[idx].data     = data;
    tests[idx].resp_req = resp_req;
    tests[idx].inhibit  = inhibit;
    tests[idx].alt_pin  = alt_pin;
  endtask

  task automatic report_mismatch(input string name, input string exp_s, input string act_s);
    $display("[ERROR] %s: expected %s, actual %s", name, exp_s, act_s);
    $display("CHECKS FAILED");
    $fatal(1, "value mismatch");
  endtask

  task automatic check_resp(input string name, input resp_t exp, input resp_t act);
    if (act !== exp) report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  task automatic check_mac(input string name, input mac_t exp, input mac_t act);
    if (act !== exp) report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  task automatic check_data(input string name, input cmd_data_t exp, input cmd_data_t act);
    if (act !== exp) report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  task automatic check_spi(input string name, input spi_word_t exp, input spi_word_t act);
    if (act !== exp) report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) report_mismatch(name, $sformatf("%b", exp), $sformatf("%b", act));
  endtask

  ////////////////////////////////////////////////////////////
  // four-phase host driver

  task automatic send_cmd(input entry_t t, input cmd_data_t data);
    @(posedge clk_ctrl);
    cmd_addr_i      <= t.addr;
    cmd_data_i      <= data;
    cmd_resp_req_i  <= t.resp_req;
    tx_inhibit_i    <= t.inhibit;
    alternate_mac_i <= t.alt_pin;
    cmd_req_i       <= 1'b1;
    @(negedge clk_ctrl);
    while (!cmd_ack_o) @(negedge clk_ctrl);
    @(posedge clk_ctrl);
    cmd_req_i <= 1'b0;
    @(negedge clk_ctrl);
    while (cmd_ack_o) @(negedge clk_ctrl);
  endtask

  task automatic update_model(input entry_t t, input cmd_data_t data);
    case (t.addr)
      `HL_ADDR_KEY: begin
        m_run = data[`HL_KEY_RUN_BIT];
        m_ptt = data[`HL_KEY_PTT_BIT];
        m_cw  = data[`HL_KEY_CW_BIT];
      end
      `HL_ADDR_IP:  m_ip = data;
      `HL_ADDR_MAC: begin
        m_alt_mac = data[15:0];
        m_cfg     = data[23:16];
      end
      default: ;
    endcase
    m_tx_on = (m_ptt | m_cw) & ~t.inhibit;
    if (t.resp_req) begin
      m_resp.run   = m_run;
      m_resp.tx_on = m_tx_on;
      m_resp.addr  = t.addr;
      m_resp.data  = data;
    end
  endtask

  task automatic check_outputs(input string name, input entry_t t, input cmd_data_t data);
    check_resp({name, " resp"}, m_resp, resp_o);
    check_bit({name, " led_run"}, m_run, led_run_o);
    check_bit({name, " tx_on"}, m_tx_on, tx_on_o);
    check_bit({name, " led_tx"}, m_tx_on, led_tx_o);
    check_data({name, " ip"}, m_ip, static_ip_o);
    check_mac({name, " mac"}, expect_mac(m_alt_mac, m_cfg, t.alt_pin), local_mac_o);
    check_bit({name, " sen_n"}, 1'b1, rffe_ad9866_sen_n_o);
    if (t.addr == `HL_ADDR_AD9866) begin
      check_spi({name, " spi word"}, data[`HL_SPI_W-1:0], spi_cap);
      check_data({name, " sclk rises"}, 32'd16, spi_rises);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus

  initial begin
    // IP and AD9866 data is replaced from the xorshift stream
    set_entry(0,  "key_run",        `HL_ADDR_KEY,    32'h0000_0001, 1'b1, 1'b0, 1'b0);
    set_entry(1,  "key_ptt",        `HL_ADDR_KEY,    32'h0000_0003, 1'b1, 1'b0, 1'b0);
    set_entry(2,  "key_ptt_inhib",  `HL_ADDR_KEY,    32'h0000_0003, 1'b1, 1'b1, 1'b0);
    set_entry(3,  "key_cw_noresp",  `HL_ADDR_KEY,    32'h0000_0005, 1'b0, 1'b0, 1'b0);
    set_entry(4,  "key_cw_inhib",   `HL_ADDR_KEY,    32'hFFFF_FFFC, 1'b1, 1'b1, 1'b0);
    set_entry(5,  "key_off",        `HL_ADDR_KEY,    32'h0000_0000, 1'b1, 1'b0, 1'b0);
    set_entry(6,  "ip_write",       `HL_ADDR_IP,     32'h0,         1'b1, 1'b0, 1'b0);
    set_entry(7,  "ip_rewrite",     `HL_ADDR_IP,     32'h0,         1'b0, 1'b0, 1'b1);
    set_entry(8,  "mac_pin_low",    `HL_ADDR_MAC,    32'h00BF_ABCD, 1'b1, 1'b0, 1'b0);
    set_entry(9,  "mac_pin_high",   `HL_ADDR_MAC,    32'h00BF_ABCD, 1'b0, 1'b0, 1'b1);
    set_entry(10, "mac_alt",        `HL_ADDR_MAC,    32'h0040_1234, 1'b1, 1'b0, 1'b0);
    set_entry(11, "mac_alt_pin",    `HL_ADDR_MAC,    32'h0040_5678, 1'b0, 1'b0, 1'b1);
    set_entry(12, "spi_write_a",    `HL_ADDR_AD9866, 32'h0,         1'b1, 1'b0, 1'b0);
    set_entry(13, "spi_write_b",    `HL_ADDR_AD9866, 32'h0,         1'b0, 1'b1, 1'b1);
    set_entry(14, "unused_addr",    6'h15,           32'hDEAD_BEEF, 1'b0, 1'b0, 1'b1);

    clk_ctrl        = 1'b0;
    rst_n_i         = 1'b0;
    cmd_req_i       = 1'b0;
    cmd_addr_i      = '0;
    cmd_data_i      = '0;
    cmd_resp_req_i  = 1'b0;
    tx_inhibit_i    = 1'b0;
    alternate_mac_i = 1'b0;
    rng             = 32'd62;

    m_run     = 1'b0;
    m_ptt     = 1'b0;
    m_cw      = 1'b0;
    m_tx_on   = 1'b0;
    m_ip      = '0;
    m_alt_mac = '0;
    m_cfg     = '0;
    m_resp    = '0;

    repeat (16) @(posedge clk_ctrl);
    rst_n_i <= 1'b1;
    @(negedge clk_ctrl);
    cur = '0;
    check_bit("reset ack", 1'b0, cmd_ack_o);
    check_outputs("reset", cur, '0);
    check_bit("reset sclk", 1'b0, rffe_ad9866_sclk_o);
    check_bit("reset sdio", 1'b0, rffe_ad9866_sdio_o);

    for (int i = 0; i < n_tests; i++) begin
      cur      = tests[i];
      cur_data = cur.data;
      if (cur.addr == `HL_ADDR_IP || cur.addr == `HL_ADDR_AD9866) begin
        rng      = xorshift32(rng);
        cur_data = rng;
      end
      send_cmd(cur, cur_data);
      update_model(cur, cur_data);
      check_outputs(names[i], cur, cur_data);
    end

    $display("ALL CHECKS PASSED");
    $finish;
  end

  // run limit from the table length
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < timeout_cycles) begin
      @(posedge clk_ctrl);
      cycle_cnt = cycle_cnt + 1;
    end
    $display("timeout: DUT stopped acknowledging within %0d cycles", timeout_cycles);
    $display("CHECKS FAILED");
    $fatal(1, "simulation timeout");
  end

endmodule

//--- src.f
+incdir+common
common/hl_pkg.sv
common/cmd_if.sv
hw/cmd_ctrl.sv
hw/radio_keying.sv
hw/identity_regs.sv
hw/ad9866/ad9866_spi.sv
hw/hl_core.sv
sim/hl_core_assert.sv
sim/hl_core_tb.sv

//--- Makefile
# Verilator build and run of the host command path testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f src.f \
		--top-module hl_core_tb -Mdir obj_dir
	./obj_dir/Vhl_core_tb | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
